//--- source/afu_pkg.sv
// Shared widths, depths and source tags
// Request and response payload structs
package afu_pkg;

    localparam int ADDR_W       = 32;
    localparam int DATA_W       = 64;
    localparam int PAGE_OFS_W   = 12;
    // Page table index comes from virtual address bits 15..12
    localparam int PT_IDX_W     = 4;
    localparam int PPN_W        = 20;

    localparam int SRC_CREDITS  = 2;
    localparam int XLATE_DEPTH  = 2;
    localparam int HOST_CREDITS = 4;
    localparam int FAULT_DEPTH  = 2;

    localparam logic SRC_DMA    = 1'b0;
    localparam logic SRC_KERNEL = 1'b1;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              write;
        logic [DATA_W-1:0] wdata;
        logic              src;
    } mem_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              src;
        logic              err;
    } rsp_t;

endpackage

//--- source/mem_req_if.sv
`timescale 1ns/1ps
// Credit-controlled request channel between pipeline stages
interface mem_req_if;

    logic              valid;
    afu_pkg::mem_req_t req;
    // Pulses once for every entry the receiver frees
    logic              credit;

    modport sender (
        output valid,
        output req,
        input  credit
    );

    modport receiver (
        input  valid,
        input  req,
        output credit
    );

endinterface

//--- source/credit_fifo.sv
`timescale 1ns/1ps
// Receiver-side circular buffer for credit flow control
// One credit pulse goes back per pop
module credit_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     not_empty,
    output logic     credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            credit <= pop;
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign pop_data  = mem[rd_ptr];
    assign not_empty = (count != '0);

    // A sender that honours its credits never finds the buffer full
    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        push |-> (count != CNT_W'(DEPTH)));

endmodule

//--- source/req_arbiter.sv
`timescale 1ns/1ps
// Stage 1 request buffers per source and round-robin grant
module req_arbiter (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              dma_valid,
    input  afu_pkg::mem_req_t dma_req,
    output logic              dma_credit,
    input  logic              kernel_valid,
    input  afu_pkg::mem_req_t kernel_req,
    output logic              kernel_credit,
    mem_req_if.sender         out
);

    localparam int CNT_W = $clog2(afu_pkg::XLATE_DEPTH + 1);

    afu_pkg::mem_req_t dma_head;
    afu_pkg::mem_req_t kernel_head;
    afu_pkg::mem_req_t granted;
    logic              dma_ne;
    logic              kernel_ne;
    logic              grant;
    logic              pick_kernel;
    logic              last_src;
    logic [CNT_W-1:0]  credits;

    credit_fifo #(
        .payload_t (afu_pkg::mem_req_t),
        .DEPTH     (afu_pkg::SRC_CREDITS)
    ) u_dma_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (dma_valid),
        .push_data (dma_req),
        .pop       (grant && !pick_kernel),
        .pop_data  (dma_head),
        .not_empty (dma_ne),
        .credit    (dma_credit)
    );

    credit_fifo #(
        .payload_t (afu_pkg::mem_req_t),
        .DEPTH     (afu_pkg::SRC_CREDITS)
    ) u_kernel_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (kernel_valid),
        .push_data (kernel_req),
        .pop       (grant && pick_kernel),
        .pop_data  (kernel_head),
        .not_empty (kernel_ne),
        .credit    (kernel_credit)
    );

    // Kernel wins when alone, or when DMA went last
    assign pick_kernel = kernel_ne && (!dma_ne || last_src == afu_pkg::SRC_DMA);
    assign grant       = (credits != '0) && (dma_ne || kernel_ne);

    always_comb begin
        granted     = pick_kernel ? kernel_head : dma_head;
        granted.src = pick_kernel ? afu_pkg::SRC_KERNEL : afu_pkg::SRC_DMA;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out.valid <= 1'b0;
            credits   <= CNT_W'(afu_pkg::XLATE_DEPTH);
            last_src  <= afu_pkg::SRC_KERNEL;
        end else begin
            out.valid <= grant;
            credits   <= credits - CNT_W'(grant) + CNT_W'(out.credit);
            if (grant) begin
                last_src <= granted.src;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            out.req <= granted;
        end
    end

    // Returned credits can never exceed what the translate buffer holds
    a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
        credits <= CNT_W'(afu_pkg::XLATE_DEPTH));

endmodule

//--- source/va_translate.sv
`timescale 1ns/1ps
// Stage 2 page table, address translation and fault detection
// Faulting reads are answered from a local response queue
module va_translate (
    input  logic                         clk,
    input  logic                         arst_n,
    mem_req_if.receiver                  in,
    input  logic                         mmio_write,
    input  logic [afu_pkg::PT_IDX_W-1:0] mmio_address,
    input  logic [afu_pkg::PPN_W:0]      mmio_writedata,
    output logic                         host_req_valid,
    output afu_pkg::mem_req_t            host_req,
    input  logic                         host_credit,
    output logic                         fault_rsp_valid,
    output afu_pkg::rsp_t                fault_rsp,
    input  logic                         fault_rsp_pop,
    output logic                         xlate_fault
);

    localparam int PT_ENTRIES  = 1 << afu_pkg::PT_IDX_W;
    localparam int HOST_CNT_W  = $clog2(afu_pkg::HOST_CREDITS + 1);
    localparam int FAULT_CNT_W = $clog2(afu_pkg::FAULT_DEPTH + 1);
    localparam int TAG_LSB     = afu_pkg::PAGE_OFS_W + afu_pkg::PT_IDX_W;

    afu_pkg::mem_req_t            head;
    afu_pkg::rsp_t                fault_entry;
    logic                         head_valid;
    logic                         pop;
    logic                         hit;
    logic                         fault_push;
    logic                         fault_credit;
    logic [afu_pkg::PT_IDX_W-1:0] idx;
    logic [PT_ENTRIES-1:0]        pt_valid;
    logic [afu_pkg::PPN_W-1:0]    pt_ppn [PT_ENTRIES];
    logic [HOST_CNT_W-1:0]        host_cnt;
    logic [FAULT_CNT_W-1:0]       fault_cnt;

    credit_fifo #(
        .payload_t (afu_pkg::mem_req_t),
        .DEPTH     (afu_pkg::XLATE_DEPTH)
    ) u_in_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (in.valid),
        .push_data (in.req),
        .pop       (pop),
        .pop_data  (head),
        .not_empty (head_valid),
        .credit    (in.credit)
    );

    credit_fifo #(
        .payload_t (afu_pkg::rsp_t),
        .DEPTH     (afu_pkg::FAULT_DEPTH)
    ) u_fault_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (fault_push),
        .push_data (fault_entry),
        .pop       (fault_rsp_pop),
        .pop_data  (fault_rsp),
        .not_empty (fault_rsp_valid),
        .credit    (fault_credit)
    );

    // Upper address bits must be zero and the entry valid
    assign idx = head.addr[afu_pkg::PAGE_OFS_W +: afu_pkg::PT_IDX_W];
    assign hit = (head.addr[afu_pkg::ADDR_W-1:TAG_LSB] == '0) && pt_valid[idx];

    // Stall when either the host or the fault queue is out of room
    assign pop        = head_valid && (host_cnt != '0) && (fault_cnt != '0);
    assign fault_push = pop && !hit && !head.write;

    always_comb begin
        fault_entry.data = '0;
        fault_entry.src  = head.src;
        fault_entry.err  = 1'b1;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pt_valid       <= '0;
            host_cnt       <= HOST_CNT_W'(afu_pkg::HOST_CREDITS);
            fault_cnt      <= FAULT_CNT_W'(afu_pkg::FAULT_DEPTH);
            host_req_valid <= 1'b0;
            xlate_fault    <= 1'b0;
        end else begin
            if (mmio_write) begin
                pt_valid[mmio_address] <= mmio_writedata[afu_pkg::PPN_W];
            end
            host_cnt       <= host_cnt - HOST_CNT_W'(pop && hit) + HOST_CNT_W'(host_credit);
            fault_cnt      <= fault_cnt - FAULT_CNT_W'(fault_push) + FAULT_CNT_W'(fault_credit);
            host_req_valid <= pop && hit;
            xlate_fault    <= pop && !hit;
        end
    end

    always_ff @(posedge clk) begin
        if (mmio_write) begin
            pt_ppn[mmio_address] <= mmio_writedata[afu_pkg::PPN_W-1:0];
        end
        if (pop && hit) begin
            host_req.addr  <= {pt_ppn[idx], head.addr[afu_pkg::PAGE_OFS_W-1:0]};
            host_req.write <= head.write;
            host_req.wdata <= head.wdata;
            host_req.src   <= head.src;
        end
    end

    // Host never returns more credits than it was granted
    a_host_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
        host_cnt <= HOST_CNT_W'(afu_pkg::HOST_CREDITS));

endmodule

//--- source/rsp_router.sv
`timescale 1ns/1ps
// Stage 3 merges host and fault responses and steers them by source tag
module rsp_router (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       host_rsp_valid,
    input  logic [afu_pkg::DATA_W-1:0] host_rsp_data,
    input  logic                       host_rsp_src,
    input  logic                       fault_rsp_valid,
    input  afu_pkg::rsp_t              fault_rsp,
    output logic                       fault_rsp_pop,
    output logic                       dma_rsp_valid,
    output logic [afu_pkg::DATA_W-1:0] dma_rsp_data,
    output logic                       dma_rsp_err,
    output logic                       kernel_rsp_valid,
    output logic [afu_pkg::DATA_W-1:0] kernel_rsp_data,
    output logic                       kernel_rsp_err
);

    afu_pkg::rsp_t rsp;
    logic          rsp_valid;

    // Host responses cannot be stalled so faults fill idle cycles
    assign fault_rsp_pop = fault_rsp_valid && !host_rsp_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= host_rsp_valid || fault_rsp_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (host_rsp_valid) begin
            rsp.data <= host_rsp_data;
            rsp.src  <= host_rsp_src;
            rsp.err  <= 1'b0;
        end else if (fault_rsp_pop) begin
            rsp <= fault_rsp;
        end
    end

    assign dma_rsp_valid    = rsp_valid && (rsp.src == afu_pkg::SRC_DMA);
    assign kernel_rsp_valid = rsp_valid && (rsp.src == afu_pkg::SRC_KERNEL);
    assign dma_rsp_data     = rsp.data;
    assign kernel_rsp_data  = rsp.data;
    assign dma_rsp_err      = rsp.err;
    assign kernel_rsp_err   = rsp.err;

    // Locally generated responses always carry the error flag
    a_fault_err: assert property (@(posedge clk) disable iff (!arst_n)
        fault_rsp_pop |-> fault_rsp.err);

endmodule

//--- source/afu_host_path.sv
`timescale 1ns/1ps
// Host-memory request path with arbiter, translation and response routing
module afu_host_path (
    input  logic                         clk,
    input  logic                         arst_n,
    // DMA engine
    input  logic                         dma_req_valid,
    input  logic [afu_pkg::ADDR_W-1:0]   dma_req_addr,
    input  logic                         dma_req_write,
    input  logic [afu_pkg::DATA_W-1:0]   dma_req_wdata,
    output logic                         dma_credit,
    output logic                         dma_rsp_valid,
    output logic [afu_pkg::DATA_W-1:0]   dma_rsp_data,
    output logic                         dma_rsp_err,
    // Kernel SVM
    input  logic                         kernel_req_valid,
    input  logic [afu_pkg::ADDR_W-1:0]   kernel_req_addr,
    input  logic                         kernel_req_write,
    input  logic [afu_pkg::DATA_W-1:0]   kernel_req_wdata,
    output logic                         kernel_credit,
    output logic                         kernel_rsp_valid,
    output logic [afu_pkg::DATA_W-1:0]   kernel_rsp_data,
    output logic                         kernel_rsp_err,
    // Page table writes
    input  logic                         mmio_write,
    input  logic [afu_pkg::PT_IDX_W-1:0] mmio_address,
    input  logic [afu_pkg::PPN_W:0]      mmio_writedata,
    // Host memory
    output logic                         host_req_valid,
    output logic [afu_pkg::ADDR_W-1:0]   host_req_addr,
    output logic                         host_req_write,
    output logic [afu_pkg::DATA_W-1:0]   host_req_wdata,
    output logic                         host_req_src,
    input  logic                         host_credit,
    input  logic                         host_rsp_valid,
    input  logic [afu_pkg::DATA_W-1:0]   host_rsp_data,
    input  logic                         host_rsp_src,
    output logic                         xlate_fault
);

    afu_pkg::mem_req_t dma_req;
    afu_pkg::mem_req_t kernel_req;
    afu_pkg::mem_req_t host_req;
    afu_pkg::rsp_t     fault_rsp;
    logic              fault_rsp_valid;
    logic              fault_rsp_pop;

    mem_req_if arb_to_xlate ();

    assign dma_req = '{addr: dma_req_addr, write: dma_req_write,
                       wdata: dma_req_wdata, src: afu_pkg::SRC_DMA};
    assign kernel_req = '{addr: kernel_req_addr, write: kernel_req_write,
                          wdata: kernel_req_wdata, src: afu_pkg::SRC_KERNEL};

    assign host_req_addr  = host_req.addr;
    assign host_req_write = host_req.write;
    assign host_req_wdata = host_req.wdata;
    assign host_req_src   = host_req.src;

    req_arbiter u_req_arbiter (
        .clk           (clk),
        .arst_n        (arst_n),
        .dma_valid     (dma_req_valid),
        .dma_req       (dma_req),
        .dma_credit    (dma_credit),
        .kernel_valid  (kernel_req_valid),
        .kernel_req    (kernel_req),
        .kernel_credit (kernel_credit),
        .out           (arb_to_xlate.sender)
    );

    va_translate u_va_translate (
        .clk             (clk),
        .arst_n          (arst_n),
        .in              (arb_to_xlate.receiver),
        .mmio_write      (mmio_write),
        .mmio_address    (mmio_address),
        .mmio_writedata  (mmio_writedata),
        .host_req_valid  (host_req_valid),
        .host_req        (host_req),
        .host_credit     (host_credit),
        .fault_rsp_valid (fault_rsp_valid),
        .fault_rsp       (fault_rsp),
        .fault_rsp_pop   (fault_rsp_pop),
        .xlate_fault     (xlate_fault)
    );

    rsp_router u_rsp_router (
        .clk              (clk),
        .arst_n           (arst_n),
        .host_rsp_valid   (host_rsp_valid),
        .host_rsp_data    (host_rsp_data),
        .host_rsp_src     (host_rsp_src),
        .fault_rsp_valid  (fault_rsp_valid),
        .fault_rsp        (fault_rsp),
        .fault_rsp_pop    (fault_rsp_pop),
        .dma_rsp_valid    (dma_rsp_valid),
        .dma_rsp_data     (dma_rsp_data),
        .dma_rsp_err      (dma_rsp_err),
        .kernel_rsp_valid (kernel_rsp_valid),
        .kernel_rsp_data  (kernel_rsp_data),
        .kernel_rsp_err   (kernel_rsp_err)
    );

endmodule

//--- bench/tb_afu_host_path.sv
`timescale 1ns/1ps
// Testbench for the host-memory request path
// Source and host models, scoreboards, immediate assertions and watchdog
module tb_afu_host_path;

    localparam int N_PER_SRC = 40;
    localparam int LIMIT     = 2 * N_PER_SRC * 50;

    typedef struct packed {
        logic [31:0] addr;
        logic        write;
        logic [63:0] wdata;
    } exp_req_t;

    logic clk = 1'b0;
    logic arst_n, arst_q = 1'b0;
    logic dma_req_valid, dma_req_write, dma_credit, dma_rsp_valid, dma_rsp_err;
    logic kernel_req_valid, kernel_req_write, kernel_credit, kernel_rsp_valid, kernel_rsp_err;
    logic [31:0] dma_req_addr, kernel_req_addr, host_req_addr;
    logic [63:0] dma_req_wdata, kernel_req_wdata, dma_rsp_data, kernel_rsp_data;
    logic [63:0] host_req_wdata, host_rsp_data;
    logic mmio_write, host_req_valid, host_req_write, host_req_src, host_credit;
    logic host_rsp_valid, host_rsp_src, xlate_fault;
    logic [3:0]  mmio_address;
    logic [20:0] mmio_writedata;

    integer seed = 93605;
    int cycle = 0, host_reqs = 0, credits_back = 0, faults_seen = 0, faults_exp = 0;
    int sent [2], returned [2], err_pending [2];
    logic        pt_v [16];
    logic [19:0] pt_ppn [16];
    exp_req_t    exp_q [2][$];
    logic [63:0] rsp_exp_q [2][$];
    int          credit_due_q [$], rsp_due_q [$];
    logic [31:0] rsp_addr_q [$];
    logic        rsp_src_q [$];
    logic        prev_grant_src = 1'b1;

    afu_host_path u_afu_host_path (.*);

    always #4 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("[ERROR] %s = 0x%0h, expected 0x%0h", name, got, exp);
        $display("STATUS: FAIL");
        $fatal(1, "value mismatch");
    endtask

    task automatic report_failure(input string msg);
        $display("Failure: %s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "check failed");
    endtask

    // Host read data is a fixed mix of the physical address
    function automatic logic [63:0] host_data_for(input logic [31:0] addr);
        return {~addr, addr} ^ 64'h5a5a_0f0f_a5a5_f0f0;
    endfunction

    task automatic check_rsp(input logic src, input logic [63:0] data, input logic err);
        logic [63:0] exp;
        if (err) begin
            assert (err_pending[src] > 0) else report_failure("unexpected error response");
            assert (data == 64'h0) else report_mismatch("rsp_data", data, 64'h0);
            err_pending[src]--;
        end else begin
            assert (rsp_exp_q[src].size() > 0) else report_failure("unexpected read response");
            exp = rsp_exp_q[src].pop_front();
            assert (data == exp) else report_mismatch("rsp_data", data, exp);
        end
    endtask

    // Records what a pushed request must produce according to the page table copy
    task automatic expect_request(input logic src, input logic [31:0] va, input logic wr,
                                  input logic [63:0] wd);
        exp_req_t e;
        if (va[31:16] == 16'h0 && pt_v[va[15:12]]) begin
            e.addr  = {pt_ppn[va[15:12]], va[11:0]};
            e.write = wr;
            e.wdata = wd;
            exp_q[src].push_back(e);
            if (!wr) rsp_exp_q[src].push_back(host_data_for(e.addr));
        end else begin
            faults_exp++;
            if (!wr) err_pending[src]++;
        end
    endtask

    always @(posedge clk) begin
        exp_req_t e;
        logic [31:0] r;
        arst_q <= arst_n;
        cycle  <= cycle + 1;
        // Reset values hold in reset and on the first edge after release
        if (!arst_q) begin
            assert (!host_req_valid && !dma_credit && !kernel_credit && !dma_rsp_valid
                    && !kernel_rsp_valid && !xlate_fault)
                else report_failure("output active during or right after reset");
        end
        if (arst_n) begin
            if (host_req_valid) begin
                assert (host_reqs - credits_back < 4)
                    else report_failure("host request issued without a host credit");
                assert (exp_q[host_req_src].size() > 0)
                    else report_failure("host request with no matching source request");
                e = exp_q[host_req_src].pop_front();
                assert (host_req_addr == e.addr)
                    else report_mismatch("host_req_addr", {32'h0, host_req_addr},
                                         {32'h0, e.addr});
                assert (host_req_write == e.write)
                    else report_mismatch("host_req_write", {63'h0, host_req_write},
                                         {63'h0, e.write});
                assert (host_req_wdata == e.wdata)
                    else report_mismatch("host_req_wdata", host_req_wdata, e.wdata);
                host_reqs++;
                r = $random(seed);
                credit_due_q.push_back(cycle + 2 + int'(r[1:0]));
                if (!host_req_write) begin
                    rsp_due_q.push_back(cycle + 3 + int'(r[3:2]));
                    rsp_addr_q.push_back(host_req_addr);
                    rsp_src_q.push_back(host_req_src);
                end
            end
            if (host_credit) credits_back++;
            if (xlate_fault) begin
                assert (faults_seen < faults_exp)
                    else report_failure("xlate_fault pulse with no faulting request");
                faults_seen++;
            end
            if (dma_credit) begin
                assert (returned[0] < sent[0])
                    else report_failure("DMA credit returned with no request in flight");
                returned[0]++;
            end
            if (kernel_credit) begin
                assert (returned[1] < sent[1])
                    else report_failure("kernel credit returned with no request in flight");
                returned[1]++;
            end
            assert (!(dma_rsp_valid && kernel_rsp_valid))
                else report_failure("both source response valids high");
            if (dma_rsp_valid) check_rsp(1'b0, dma_rsp_data, dma_rsp_err);
            if (kernel_rsp_valid) check_rsp(1'b1, kernel_rsp_data, kernel_rsp_err);
            // With both buffers loaded the grant must switch source
            if (u_afu_host_path.u_req_arbiter.grant) begin
                if (u_afu_host_path.u_req_arbiter.dma_ne
                    && u_afu_host_path.u_req_arbiter.kernel_ne)
                    assert (u_afu_host_path.u_req_arbiter.pick_kernel != prev_grant_src)
                        else report_failure("arbiter granted the same source twice in a row");
                prev_grant_src <= u_afu_host_path.u_req_arbiter.pick_kernel;
            end
        end
    end

    // Host memory model answers in order with at most one credit and one response per cycle
    always @(negedge clk) begin
        host_credit    <= 1'b0;
        host_rsp_valid <= 1'b0;
        if (credit_due_q.size() > 0 && credit_due_q[0] <= cycle) begin
            void'(credit_due_q.pop_front());
            host_credit <= 1'b1;
        end
        if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle) begin
            void'(rsp_due_q.pop_front());
            host_rsp_valid <= 1'b1;
            host_rsp_data  <= host_data_for(rsp_addr_q.pop_front());
            host_rsp_src   <= rsp_src_q.pop_front();
        end
    end

    task automatic drive_source(input logic src, input bit full, output logic valid,
                                output logic [31:0] addr, output logic wr, output logic [63:0] wd);
        logic [31:0] r;
        r = $random(seed);
        valid = 1'b0;
        if (sent[src] < N_PER_SRC && (2 - sent[src] + returned[src]) > 0 && (full || r[31])) begin
            valid = 1'b1;
            // One in eight requests has nonzero upper address bits
            addr  = (r[30:28] == 3'd0) ? {16'h8000 | r[15:0], r[27:12]} : {16'h0, r[19:4]};
            wr    = r[24];
            wd    = {$random(seed), $random(seed)};
            sent[src]++;
            expect_request(src, addr, wr, wd);
        end
    endtask

    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("Timeout: traffic did not drain in time");
        $display("STATUS: FAIL");
        $fatal(1, "watchdog");
    end

    initial begin
        logic [31:0] r;
        {dma_req_valid, dma_req_write, kernel_req_valid, kernel_req_write} = '0;
        {dma_req_addr, kernel_req_addr, dma_req_wdata, kernel_req_wdata} = '0;
        {mmio_write, mmio_address, mmio_writedata} = '0;
        {host_credit, host_rsp_valid, host_rsp_src, host_rsp_data} = '0;
        sent = '{0, 0};
        returned = '{0, 0};
        err_pending = '{0, 0};
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk) arst_n = 1'b1;
        // Entries 12 to 15 stay invalid
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            r = $random(seed);
            pt_v[i]   = (i < 12);
            pt_ppn[i] = r[19:0];
            mmio_write     = 1'b1;
            mmio_address   = 4'(i);
            mmio_writedata = {pt_v[i], pt_ppn[i]};
        end
        @(negedge clk) mmio_write = 1'b0;
        while (sent[0] < N_PER_SRC || sent[1] < N_PER_SRC) begin
            @(negedge clk);
            drive_source(1'b0, sent[0] >= N_PER_SRC / 2, dma_req_valid, dma_req_addr,
                         dma_req_write, dma_req_wdata);
            drive_source(1'b1, sent[1] >= N_PER_SRC / 2, kernel_req_valid, kernel_req_addr,
                         kernel_req_write, kernel_req_wdata);
        end
        @(negedge clk) {dma_req_valid, kernel_req_valid} = 2'b00;
        while (exp_q[0].size() + exp_q[1].size() + rsp_exp_q[0].size() + rsp_exp_q[1].size()
               + err_pending[0] + err_pending[1] + rsp_addr_q.size() > 0
               || host_reqs != credits_back || faults_seen != faults_exp)
            @(posedge clk);
        repeat (4) @(posedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- flist.f
source/afu_pkg.sv
source/mem_req_if.sv
source/credit_fifo.sv
source/req_arbiter.sv
source/va_translate.sv
source/rsp_router.sv
source/afu_host_path.sv
bench/tb_afu_host_path.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator and run; passes only if the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module tb_afu_host_path \
    -o sim_tb_afu_host_path &&
./obj_dir/sim_tb_afu_host_path | grep "^STATUS: PASS$" || exit 1
